// ==== decodeSettings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5

// instruction field positions
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RD_MSB 25
`define RD_LSB 21
`define RA_MSB 20
`define RA_LSB 16
`define RB_MSB 15
`define RB_LSB 11

`define ZERO_REGISTER 5'd0
`define LINK_REGISTER 5'd9

`endif

// ==== decodePkg.sv ====
package decodePkg;

  typedef enum logic [3:0] {
    opJumpAlways,
    opJumpLink,
    opBranchFlagClear,
    opBranchFlagSet,
    opAluImm,
    opAluImmZero,
    opMoveHigh,
    opLoad,
    opStore,
    opAluReg,
    opSetFlag,
    opInvalid
  } opcodeClassT;

  // operation handed to execute
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluHigh,
    aluPass
  } aluOpT;

  typedef enum logic [2:0] {
    immSignExtendedHalf,
    immZeroExtendedHalf,
    immHalfMovedHigh,
    immJumpOffset,
    immSplitStore
  } immFormatT;

  typedef enum logic [1:0] {condAlways, condFlagClear, condFlagSet} jumpCondT;

  typedef enum logic [1:0] {loadNone, loadWord, loadByteZero} loadKindT;

  typedef enum logic [1:0] {storeNone, storeWord, storeByte} storeKindT;

endpackage

// ==== instructionClassifier.sv ====
`timescale 1ns/1ps
`include "decodeSettings.svh"

module instructionClassifier (
  input  logic [`DATA_WIDTH-1:0]     ir,
  output decodePkg::opcodeClassT     opClass,
  output decodePkg::aluOpT           aluOp,
  output logic [`DATA_WIDTH-1:0]     immediate,
  output logic                       usePc,
  output logic                       useImmediate,
  output logic                       isJump,
  output logic                       weDestination,
  output logic                       updateFlag,
  output logic                       validInstruction,
  output decodePkg::jumpCondT        jumpCond,
  output decodePkg::loadKindT        loadKind,
  output decodePkg::storeKindT       storeKind,
  output logic [`REG_ADDR_WIDTH-1:0] destination,
  output logic [`REG_ADDR_WIDTH-1:0] lookupOperandAAddr,
  output logic [`REG_ADDR_WIDTH-1:0] lookupOperandBAddr,
  output logic [3:0]                 compareCntrl
);
  import decodePkg::*;

  logic [5:0] opcode;
  logic [`REG_ADDR_WIDTH-1:0] rd;
  immFormatT immFormat;

  assign opcode = ir[`OPCODE_MSB:`OPCODE_LSB];
  assign rd = ir[`RD_MSB:`RD_LSB];

  always_comb
  begin
    case (opcode)
      6'b000000: opClass = opJumpAlways;
      6'b000001: opClass = opJumpLink;
      6'b000011: opClass = opBranchFlagClear;
      6'b000100: opClass = opBranchFlagSet;
      6'b100111: opClass = opAluImm;
      6'b101010: opClass = opAluImmZero;
      6'b000110: opClass = ir[16] ? opInvalid : opMoveHigh;
      6'b100001, 6'b100011: opClass = opLoad;
      6'b110101, 6'b110110: opClass = opStore;
      6'b111000: opClass = (ir[3:0] <= 4'h5 && ir[3:0] != 4'h1) ? opAluReg : opInvalid;
      // set-flag compares occupy 1110010 in the top seven bits
      6'b111001: opClass = ir[25] ? opInvalid : opSetFlag;
      default:   opClass = opInvalid;
    endcase
  end

  always_comb
  begin
    aluOp = aluPass;
    immFormat = immSignExtendedHalf;
    usePc = 1'b0;
    useImmediate = 1'b0;
    isJump = 1'b0;
    jumpCond = condAlways;
    weDestination = 1'b0;
    loadKind = loadNone;
    storeKind = storeNone;
    case (opClass)
      opJumpAlways, opJumpLink, opBranchFlagClear, opBranchFlagSet:
      begin
        // execute forms the target as pc plus offset
        aluOp = aluAdd;
        immFormat = immJumpOffset;
        usePc = 1'b1;
        useImmediate = 1'b1;
        isJump = 1'b1;
        weDestination = (opClass == opJumpLink);
        if (opClass == opBranchFlagClear)
          jumpCond = condFlagClear;
        else if (opClass == opBranchFlagSet)
          jumpCond = condFlagSet;
      end
      opAluImm:
      begin
        aluOp = aluAdd;
        useImmediate = 1'b1;
        weDestination = 1'b1;
      end
      opAluImmZero:
      begin
        aluOp = aluOr;
        immFormat = immZeroExtendedHalf;
        useImmediate = 1'b1;
        weDestination = 1'b1;
      end
      opMoveHigh:
      begin
        aluOp = aluHigh;
        immFormat = immHalfMovedHigh;
        useImmediate = 1'b1;
        weDestination = 1'b1;
      end
      opLoad:
      begin
        aluOp = aluAdd;
        useImmediate = 1'b1;
        weDestination = 1'b1;
        // nothing to fetch when the result would land in r0
        if (rd != `ZERO_REGISTER)
          loadKind = (opcode == 6'b100001) ? loadWord : loadByteZero;
      end
      opStore:
      begin
        aluOp = aluAdd;
        immFormat = immSplitStore;
        useImmediate = 1'b1;
        storeKind = (opcode == 6'b110101) ? storeWord : storeByte;
      end
      opAluReg:
      begin
        weDestination = 1'b1;
        case (ir[3:0])
          4'h0: aluOp = aluAdd;
          4'h2: aluOp = aluSub;
          4'h3: aluOp = aluAnd;
          4'h4: aluOp = aluOr;
          default: aluOp = aluXor;
        endcase
      end
      opSetFlag: aluOp = aluSub;
      default: aluOp = aluPass;
    endcase
  end

  always_comb
  begin
    case (immFormat)
      immZeroExtendedHalf: immediate = {{(`DATA_WIDTH-16){1'b0}}, ir[15:0]};
      immHalfMovedHigh:    immediate = {ir[15:0], {(`DATA_WIDTH-16){1'b0}}};
      immJumpOffset:       immediate = {{(`DATA_WIDTH-28){ir[25]}}, ir[25:0], 2'b00};
      immSplitStore:       immediate = {{(`DATA_WIDTH-16){ir[25]}}, ir[25:21], ir[10:0]};
      default:             immediate = {{(`DATA_WIDTH-16){ir[15]}}, ir[15:0]};
    endcase
  end

  assign destination = (opClass == opJumpLink) ? `LINK_REGISTER : rd;
  assign lookupOperandAAddr = ir[`RA_MSB:`RA_LSB];
  assign lookupOperandBAddr = ir[`RB_MSB:`RB_LSB];
  assign updateFlag = (opClass == opSetFlag);
  assign validInstruction = (opClass != opInvalid);
  assign compareCntrl = ir[24:21];

endmodule

// ==== operandSelect.sv ====
`timescale 1ns/1ps
`include "decodeSettings.svh"

module operandSelect (
  input  logic [`DATA_WIDTH-1:0]     pc,
  input  logic [`DATA_WIDTH-1:0]     immediate,
  input  logic [`DATA_WIDTH-1:0]     rfOperandA,
  input  logic [`DATA_WIDTH-1:0]     rfOperandB,
  input  logic [`DATA_WIDTH-1:0]     forwardedOperandA,
  input  logic [`DATA_WIDTH-1:0]     forwardedOperandB,
  input  logic [`DATA_WIDTH-1:0]     forwardedStoreData,
  input  logic                       useForwardedOperandA,
  input  logic                       useForwardedOperandB,
  input  logic                       useForwardedStoreData,
  input  logic                       usePc,
  input  logic                       useImmediate,
  input  logic [`REG_ADDR_WIDTH-1:0] lookupOperandAAddr,
  input  logic [`REG_ADDR_WIDTH-1:0] lookupOperandBAddr,
  output logic [`DATA_WIDTH-1:0]     operandANext,
  output logic [`DATA_WIDTH-1:0]     operandBNext,
  output logic [`DATA_WIDTH-1:0]     storeDataNext
);

  // r0 reads as zero even when the forward unit points at it
  assign operandANext = usePc ? pc :
                        (lookupOperandAAddr == `ZERO_REGISTER) ? '0 :
                        useForwardedOperandA ? forwardedOperandA : rfOperandA;

  assign operandBNext = useImmediate ? immediate :
                        (lookupOperandBAddr == `ZERO_REGISTER) ? '0 :
                        useForwardedOperandB ? forwardedOperandB : rfOperandB;

  assign storeDataNext = useForwardedStoreData ? forwardedStoreData : rfOperandB;

endmodule

// ==== branchControl.sv ====
`timescale 1ns/1ps

module branchControl (
  input  logic                clock,
  input  logic                arstN,
  input  logic                stall,
  input  logic                flush,
  input  logic                fastFlag,
  input  logic                resetFilterIn,
  input  logic                insertedNop,
  input  logic                isJump,
  input  decodePkg::jumpCondT jumpCond,
  output logic                jump,
  output logic                correctJumpFlush,
  output logic                exeIsJump,
  output logic                exeIsDelaySlot
);
  import decodePkg::*;

  logic isJumpReg;
  jumpCondT jumpCondReg;
  logic delaySlotReg;
  logic filterActiveReg;
  logic delaySlotIssuedReg;
  logic taken;

  assign taken = (jumpCondReg == condAlways) ||
                 (jumpCondReg == condFlagClear && !fastFlag) ||
                 (jumpCondReg == condFlagSet && fastFlag);

  // the jump resolves while its delay slot sits in decode
  assign jump = isJumpReg && taken && !stall;

  // words other than the delay slot are dropped after a taken jump until fetch redirects
  assign correctJumpFlush = filterActiveReg && !delaySlotReg && !resetFilterIn;

  assign exeIsJump = isJumpReg;
  assign exeIsDelaySlot = delaySlotIssuedReg;

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      isJumpReg <= 1'b0;
      jumpCondReg <= condAlways;
      delaySlotReg <= 1'b0;
      filterActiveReg <= 1'b0;
      delaySlotIssuedReg <= 1'b0;
    end
    else if (!stall)
    begin
      isJumpReg <= isJump && !correctJumpFlush && !flush;
      if (isJump)
        jumpCondReg <= jumpCond;
      // a bubble from fetch keeps the delay slot pending
      if (isJump && !correctJumpFlush)
        delaySlotReg <= 1'b1;
      else if (!insertedNop)
        delaySlotReg <= 1'b0;
      if (flush)
        filterActiveReg <= 1'b0;
      else if (jump)
        filterActiveReg <= 1'b1;
      else if (resetFilterIn)
        filterActiveReg <= 1'b0;
      delaySlotIssuedReg <= delaySlotReg && !insertedNop;
    end
  end

endmodule

// ==== executeStageRegister.sv ====
`timescale 1ns/1ps
`include "decodeSettings.svh"

module executeStageRegister (
  input  logic                       clock,
  input  logic                       arstN,
  input  logic                       stall,
  input  logic                       flush,
  input  logic                       correctJumpFlush,
  input  logic [`DATA_WIDTH-1:0]     operandANext,
  input  logic [`DATA_WIDTH-1:0]     operandBNext,
  input  logic [`DATA_WIDTH-1:0]     storeDataNext,
  input  logic [`DATA_WIDTH-1:0]     pc,
  input  decodePkg::aluOpT           aluOp,
  input  decodePkg::loadKindT        loadKind,
  input  decodePkg::storeKindT       storeKind,
  input  logic [`REG_ADDR_WIDTH-1:0] destination,
  input  logic                       weDestination,
  input  logic                       updateFlag,
  input  logic [3:0]                 compareCntrl,
  input  logic                       validInstruction,
  output logic [`DATA_WIDTH-1:0]     exeOperandA,
  output logic [`DATA_WIDTH-1:0]     exeOperandB,
  output logic [`DATA_WIDTH-1:0]     exeStoreData,
  output logic [`DATA_WIDTH-1:0]     exeInstructionAddress,
  output decodePkg::aluOpT           exeAluOp,
  output decodePkg::loadKindT        exeLoad,
  output decodePkg::storeKindT       exeStore,
  output logic [`REG_ADDR_WIDTH-1:0] exeDestination,
  output logic                       exeWeDestination,
  output logic                       exeUpdateFlag,
  output logic [3:0]                 exeCompareCntrl,
  output logic                       exeValidInstruction
);
  import decodePkg::*;

  logic squash;

  assign squash = flush || correctJumpFlush;

  // a squashed word still counts as valid but has no side effects
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      exeWeDestination <= 1'b0;
      exeLoad <= loadNone;
      exeStore <= storeNone;
      exeUpdateFlag <= 1'b0;
      exeValidInstruction <= 1'b1;
    end
    else if (!stall)
    begin
      exeWeDestination <= weDestination && !squash;
      exeLoad <= squash ? loadNone : loadKind;
      exeStore <= squash ? storeNone : storeKind;
      exeUpdateFlag <= updateFlag && !squash;
      exeValidInstruction <= validInstruction || squash;
    end
  end

  always_ff @(posedge clock)
  begin
    if (!stall)
    begin
      exeOperandA <= operandANext;
      exeOperandB <= operandBNext;
      exeStoreData <= storeDataNext;
      exeInstructionAddress <= pc;
      exeAluOp <= aluOp;
      exeDestination <= destination;
      exeCompareCntrl <= compareCntrl;
    end
  end

  noLoadWithStore: assert property (@(posedge clock) disable iff (!arstN)
    !(exeLoad != loadNone && exeStore != storeNone));

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps
`include "decodeSettings.svh"

module decodeStage (
  input  logic                       clock,
  input  logic                       arstN,
  input  logic [`DATA_WIDTH-1:0]     ir,
  input  logic [`DATA_WIDTH-1:0]     pc,
  input  logic                       stall,
  input  logic                       flush,
  input  logic                       fastFlag,
  input  logic                       resetFilterIn,
  input  logic                       insertedNop,
  output logic                       jump,
  output logic [`REG_ADDR_WIDTH-1:0] lookupOperandAAddr,
  output logic [`REG_ADDR_WIDTH-1:0] lookupOperandBAddr,
  input  logic [`DATA_WIDTH-1:0]     rfOperandA,
  input  logic [`DATA_WIDTH-1:0]     rfOperandB,
  input  logic [`DATA_WIDTH-1:0]     forwardedOperandA,
  input  logic [`DATA_WIDTH-1:0]     forwardedOperandB,
  input  logic [`DATA_WIDTH-1:0]     forwardedStoreData,
  input  logic                       useForwardedOperandA,
  input  logic                       useForwardedOperandB,
  input  logic                       useForwardedStoreData,
  output logic [`DATA_WIDTH-1:0]     exeOperandA,
  output logic [`DATA_WIDTH-1:0]     exeOperandB,
  output logic [`DATA_WIDTH-1:0]     exeStoreData,
  output logic [`DATA_WIDTH-1:0]     exeInstructionAddress,
  output decodePkg::aluOpT           exeAluOp,
  output decodePkg::loadKindT        exeLoad,
  output decodePkg::storeKindT       exeStore,
  output logic [`REG_ADDR_WIDTH-1:0] exeDestination,
  output logic                       exeWeDestination,
  output logic                       exeUpdateFlag,
  output logic [3:0]                 exeCompareCntrl,
  output logic                       exeValidInstruction,
  output logic                       exeIsJump,
  output logic                       exeIsDelaySlot
);
  import decodePkg::*;

  aluOpT aluOp;
  jumpCondT jumpCond;
  loadKindT loadKind;
  storeKindT storeKind;
  logic [`DATA_WIDTH-1:0] immediate;
  logic [`DATA_WIDTH-1:0] operandANext;
  logic [`DATA_WIDTH-1:0] operandBNext;
  logic [`DATA_WIDTH-1:0] storeDataNext;
  logic [`REG_ADDR_WIDTH-1:0] destination;
  logic [3:0] compareCntrl;
  logic usePc;
  logic useImmediate;
  logic isJump;
  logic weDestination;
  logic updateFlag;
  logic validInstruction;
  logic correctJumpFlush;

  instructionClassifier u_instructionClassifier (
    .ir                 (ir),
    .opClass            (),
    .aluOp              (aluOp),
    .immediate          (immediate),
    .usePc              (usePc),
    .useImmediate       (useImmediate),
    .isJump             (isJump),
    .weDestination      (weDestination),
    .updateFlag         (updateFlag),
    .validInstruction   (validInstruction),
    .jumpCond           (jumpCond),
    .loadKind           (loadKind),
    .storeKind          (storeKind),
    .destination        (destination),
    .lookupOperandAAddr (lookupOperandAAddr),
    .lookupOperandBAddr (lookupOperandBAddr),
    .compareCntrl       (compareCntrl)
  );

  operandSelect u_operandSelect (
    .pc                    (pc),
    .immediate             (immediate),
    .rfOperandA            (rfOperandA),
    .rfOperandB            (rfOperandB),
    .forwardedOperandA     (forwardedOperandA),
    .forwardedOperandB     (forwardedOperandB),
    .forwardedStoreData    (forwardedStoreData),
    .useForwardedOperandA  (useForwardedOperandA),
    .useForwardedOperandB  (useForwardedOperandB),
    .useForwardedStoreData (useForwardedStoreData),
    .usePc                 (usePc),
    .useImmediate          (useImmediate),
    .lookupOperandAAddr    (lookupOperandAAddr),
    .lookupOperandBAddr    (lookupOperandBAddr),
    .operandANext          (operandANext),
    .operandBNext          (operandBNext),
    .storeDataNext         (storeDataNext)
  );

  branchControl u_branchControl (
    .clock            (clock),
    .arstN            (arstN),
    .stall            (stall),
    .flush            (flush),
    .fastFlag         (fastFlag),
    .resetFilterIn    (resetFilterIn),
    .insertedNop      (insertedNop),
    .isJump           (isJump),
    .jumpCond         (jumpCond),
    .jump             (jump),
    .correctJumpFlush (correctJumpFlush),
    .exeIsJump        (exeIsJump),
    .exeIsDelaySlot   (exeIsDelaySlot)
  );

  executeStageRegister u_executeStageRegister (
    .clock                 (clock),
    .arstN                 (arstN),
    .stall                 (stall),
    .flush                 (flush),
    .correctJumpFlush      (correctJumpFlush),
    .operandANext          (operandANext),
    .operandBNext          (operandBNext),
    .storeDataNext         (storeDataNext),
    .pc                    (pc),
    .aluOp                 (aluOp),
    .loadKind              (loadKind),
    .storeKind             (storeKind),
    .destination           (destination),
    .weDestination         (weDestination),
    .updateFlag            (updateFlag),
    .compareCntrl          (compareCntrl),
    .validInstruction      (validInstruction),
    .exeOperandA           (exeOperandA),
    .exeOperandB           (exeOperandB),
    .exeStoreData          (exeStoreData),
    .exeInstructionAddress (exeInstructionAddress),
    .exeAluOp              (exeAluOp),
    .exeLoad               (exeLoad),
    .exeStore              (exeStore),
    .exeDestination        (exeDestination),
    .exeWeDestination      (exeWeDestination),
    .exeUpdateFlag         (exeUpdateFlag),
    .exeCompareCntrl       (exeCompareCntrl),
    .exeValidInstruction   (exeValidInstruction)
  );

endmodule

// ==== tb_decodeStage.sv ====
`timescale 1ns/1ps
`include "decodeSettings.svh"

module tb_decodeStage;
  import decodePkg::*;

  // stimulus control bits
  localparam logic [7:0] ctlNone = 8'h00;
  localparam logic [7:0] ctlStall = 8'h80;
  localparam logic [7:0] ctlFlush = 8'h40;
  localparam logic [7:0] ctlFast = 8'h20;
  localparam logic [7:0] ctlNop = 8'h10;
  localparam logic [7:0] ctlResetFilter = 8'h08;
  localparam logic [7:0] ctlFwdA = 8'h04;
  localparam logic [7:0] ctlFwdB = 8'h02;
  localparam logic [7:0] ctlFwdStore = 8'h01;

  // expected single-bit outputs
  localparam logic [5:0] expWe = 6'h20;
  localparam logic [5:0] expUf = 6'h10;
  localparam logic [5:0] expValid = 6'h08;
  localparam logic [5:0] expJump = 6'h04;
  localparam logic [5:0] expIsJump = 6'h02;
  localparam logic [5:0] expDelaySlot = 6'h01;

  // srcPcImm selects pc for operand A and the immediate for operand B
  localparam int srcZero = 0;
  localparam int srcPcImm = 1;
  localparam int srcFwd = 2;
  localparam int srcRf = 3;

  typedef struct {
    string name;
    logic [31:0] ir;
    logic [31:0] pc;
    logic [7:0] ctl;
    int srcA;
    int srcB;
    logic [31:0] imm;
    aluOpT aluOp;
    loadKindT ld;
    storeKindT st;
    logic [4:0] dest;
    logic [5:0] flags;
    logic [31:0] rfA;
    logic [31:0] rfB;
    logic [31:0] fwdA;
    logic [31:0] fwdB;
    logic [31:0] fwdStore;
  } rowT;

  logic clock;
  logic arstN;
  logic [`DATA_WIDTH-1:0] ir;
  logic [`DATA_WIDTH-1:0] pc;
  logic stall;
  logic flush;
  logic fastFlag;
  logic resetFilterIn;
  logic insertedNop;
  logic jump;
  logic [`REG_ADDR_WIDTH-1:0] lookupOperandAAddr;
  logic [`REG_ADDR_WIDTH-1:0] lookupOperandBAddr;
  logic [`DATA_WIDTH-1:0] rfOperandA;
  logic [`DATA_WIDTH-1:0] rfOperandB;
  logic [`DATA_WIDTH-1:0] forwardedOperandA;
  logic [`DATA_WIDTH-1:0] forwardedOperandB;
  logic [`DATA_WIDTH-1:0] forwardedStoreData;
  logic useForwardedOperandA;
  logic useForwardedOperandB;
  logic useForwardedStoreData;
  logic [`DATA_WIDTH-1:0] exeOperandA;
  logic [`DATA_WIDTH-1:0] exeOperandB;
  logic [`DATA_WIDTH-1:0] exeStoreData;
  logic [`DATA_WIDTH-1:0] exeInstructionAddress;
  aluOpT exeAluOp;
  loadKindT exeLoad;
  storeKindT exeStore;
  logic [`REG_ADDR_WIDTH-1:0] exeDestination;
  logic exeWeDestination;
  logic exeUpdateFlag;
  logic [3:0] exeCompareCntrl;
  logic exeValidInstruction;
  logic exeIsJump;
  logic exeIsDelaySlot;

  rowT rows[$];
  rowT held;
  logic [31:0] heldA;
  logic [31:0] heldB;
  logic [31:0] heldStore;
  int rowErrors[$];
  int errors = 0;
  int failedRows = 0;
  int cycles = 0;
  int cycleLimit = 1000;

  decodeStage u_decodeStage (.*);

  always #10 clock = ~clock;

  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles > cycleLimit)
    begin
      $display("timeout: the run went past %0d cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] encR(logic [4:0] rd, logic [4:0] ra, logic [4:0] rb,
                                        logic [3:0] fn);
    return {6'b111000, rd, ra, rb, 7'b0, fn};
  endfunction

  function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rd, logic [4:0] ra,
                                        logic [15:0] imm);
    return {op, rd, ra, imm};
  endfunction

  function automatic logic [31:0] encStore(logic [5:0] op, logic [15:0] imm, logic [4:0] ra,
                                            logic [4:0] rb);
    return {op, imm[15:11], ra, rb, imm[10:0]};
  endfunction

  function automatic logic [31:0] encJump(logic [5:0] op, logic [25:0] offset);
    return {op, offset};
  endfunction

  function automatic logic [31:0] encSetFlag(logic [3:0] cmp, logic [4:0] ra, logic [4:0] rb);
    return {7'b1110010, cmp, ra, rb, 11'b0};
  endfunction

  function automatic logic [31:0] sourceValue(int src, logic [31:0] special, logic [31:0] fwd,
                                               logic [31:0] rf);
    case (src)
      srcZero: return 32'h0;
      srcPcImm: return special;
      srcFwd: return fwd;
      default: return rf;
    endcase
  endfunction

  task automatic addRow(input string name, input logic [31:0] word, input logic [7:0] ctl,
                        input int srcA, input int srcB, input logic [31:0] imm,
                        input aluOpT aluOp, input loadKindT ld, input storeKindT st,
                        input logic [4:0] dest, input logic [5:0] flags);
    rowT r;
    r.name = name;
    r.ir = word;
    r.pc = 32'h1000 + 32'(4 * rows.size());
    r.ctl = ctl;
    r.srcA = srcA;
    r.srcB = srcB;
    r.imm = imm;
    r.aluOp = aluOp;
    r.ld = ld;
    r.st = st;
    r.dest = dest;
    r.flags = flags;
    r.rfA = $urandom;
    r.rfB = $urandom;
    r.fwdA = $urandom;
    r.fwdB = $urandom;
    r.fwdStore = $urandom;
    rows.push_back(r);
    rowErrors.push_back(0);
  endtask

  task automatic buildTable();
    logic [5:0] v;
    v = expWe | expValid;
    addRow("add rf", encR(3, 4, 5, 0), ctlNone, srcRf, srcRf, 0, aluAdd, loadNone, storeNone,
           3, v);
    addRow("sub fwd", encR(6, 7, 8, 2), ctlFwdA | ctlFwdB, srcFwd, srcFwd, 0, aluSub, loadNone,
           storeNone, 6, v);
    addRow("and r0 over fwd", encR(3, 0, 0, 3), ctlFwdA | ctlFwdB, srcZero, srcZero, 0, aluAnd,
           loadNone, storeNone, 3, v);
    addRow("or", encR(3, 4, 5, 4), ctlFwdB, srcRf, srcFwd, 0, aluOr, loadNone, storeNone, 3, v);
    addRow("xor", encR(3, 4, 5, 5), ctlNone, srcRf, srcRf, 0, aluXor, loadNone, storeNone, 3, v);
    addRow("addi", encI(6'b100111, 3, 4, 16'hFFF0), ctlNone, srcRf, srcPcImm, 32'hFFFFFFF0,
           aluAdd, loadNone, storeNone, 3, v);
    addRow("ori", encI(6'b101010, 3, 0, 16'h8001), ctlNone, srcZero, srcPcImm, 32'h00008001,
           aluOr, loadNone, storeNone, 3, v);
    addRow("movhi", encI(6'b000110, 3, 0, 16'h1234), ctlNone, srcZero, srcPcImm, 32'h12340000,
           aluHigh, loadNone, storeNone, 3, v);
    addRow("set flag", encSetFlag(4'h1, 4, 5), ctlFwdA, srcFwd, srcRf, 0, aluSub, loadNone,
           storeNone, 1, expUf | expValid);
    addRow("invalid", 32'hFC000000, ctlNone, srcZero, srcZero, 0, aluPass, loadNone, storeNone,
           0, 6'h0);
    addRow("stall 1", encR(3, 4, 5, 0), ctlStall, srcRf, srcRf, 0, aluAdd, loadNone, storeNone,
           0, 6'h0);
    addRow("stall 2", encR(3, 4, 5, 2), ctlStall, srcRf, srcRf, 0, aluAdd, loadNone, storeNone,
           0, 6'h0);
    addRow("resume", encR(3, 4, 5, 0), ctlNone, srcRf, srcRf, 0, aluAdd, loadNone, storeNone,
           3, v);
    addRow("lwz", encI(6'b100001, 3, 4, 16'h0010), ctlNone, srcRf, srcPcImm, 32'h10, aluAdd,
           loadWord, storeNone, 3, v);
    addRow("lbz to r0", encI(6'b100011, 0, 4, 16'hFFFC), ctlNone, srcRf, srcPcImm, 32'hFFFFFFFC,
           aluAdd, loadNone, storeNone, 0, v);
    addRow("lbz", encI(6'b100011, 7, 0, 16'h0004), ctlNone, srcZero, srcPcImm, 32'h4, aluAdd,
           loadByteZero, storeNone, 7, v);
    addRow("sw fwd", encStore(6'b110101, 16'h8004, 4, 5), ctlFwdA | ctlFwdStore, srcFwd,
           srcPcImm, 32'hFFFF8004, aluAdd, loadNone, storeWord, 16, expValid);
    addRow("sb rf", encStore(6'b110110, 16'h0013, 0, 5), ctlNone, srcZero, srcPcImm, 32'h13,
           aluAdd, loadNone, storeByte, 0, expValid);
    addRow("j", encJump(6'b000000, 26'h10), ctlNone, srcPcImm, srcPcImm, 32'h40, aluAdd,
           loadNone, storeNone, 0, expValid | expIsJump);
    addRow("stall on jump", encR(3, 4, 5, 0), ctlStall, srcRf, srcRf, 0, aluAdd, loadNone,
           storeNone, 0, 6'h0);
    addRow("j delay slot", encI(6'b100111, 3, 4, 16'h1), ctlNone, srcRf, srcPcImm, 32'h1,
           aluAdd, loadNone, storeNone, 3, v | expJump | expDelaySlot);
    addRow("j squashed", encI(6'b100001, 3, 4, 16'h8), ctlNone, srcRf, srcPcImm, 32'h8, aluAdd,
           loadNone, storeNone, 3, expValid);
    addRow("filter reset", encR(3, 4, 5, 0), ctlResetFilter, srcRf, srcRf, 0, aluAdd, loadNone,
           storeNone, 3, v);
    addRow("bf", encJump(6'b000100, 26'h3FFFFFE), ctlNone, srcPcImm, srcPcImm, 32'hFFFFFFF8,
           aluAdd, loadNone, storeNone, 31, expValid | expIsJump);
    addRow("bf slot taken", encR(3, 4, 5, 0), ctlFast, srcRf, srcRf, 0, aluAdd, loadNone,
           storeNone, 3, v | expJump | expDelaySlot);
    addRow("bf squash blocked", encI(6'b100001, 3, 4, 16'h8), ctlResetFilter, srcRf, srcPcImm,
           32'h8, aluAdd, loadWord, storeNone, 3, v);
    addRow("bf", encJump(6'b000100, 26'h4), ctlNone, srcPcImm, srcPcImm, 32'h10, aluAdd,
           loadNone, storeNone, 0, expValid | expIsJump);
    addRow("bf slot not taken", encR(3, 4, 5, 0), ctlNone, srcRf, srcRf, 0, aluAdd, loadNone,
           storeNone, 3, v | expDelaySlot);
    addRow("after bf", encI(6'b100001, 3, 4, 16'h8), ctlNone, srcRf, srcPcImm, 32'h8, aluAdd,
           loadWord, storeNone, 3, v);
    addRow("bnf", encJump(6'b000011, 26'h8), ctlNone, srcPcImm, srcPcImm, 32'h20, aluAdd,
           loadNone, storeNone, 0, expValid | expIsJump);
    addRow("bnf slot taken", encR(3, 4, 5, 0), ctlNone, srcRf, srcRf, 0, aluAdd, loadNone,
           storeNone, 3, v | expJump | expDelaySlot);
    addRow("bnf squashed", encStore(6'b110101, 16'h0008, 4, 5), ctlNone, srcRf, srcPcImm, 32'h8,
           aluAdd, loadNone, storeNone, 0, expValid);
    // the filter is held off here so that only the flush can squash
    addRow("flush", encI(6'b100001, 3, 4, 16'h8), ctlFlush | ctlResetFilter, srcRf, srcPcImm,
           32'h8, aluAdd, loadNone, storeNone, 3, expValid);
    addRow("bnf", encJump(6'b000011, 26'h8), ctlNone, srcPcImm, srcPcImm, 32'h20, aluAdd,
           loadNone, storeNone, 0, expValid | expIsJump);
    addRow("bnf slot not taken", encR(3, 4, 5, 0), ctlFast, srcRf, srcRf, 0, aluAdd, loadNone,
           storeNone, 3, v | expDelaySlot);
    addRow("jal", encJump(6'b000001, 26'h20), ctlNone, srcPcImm, srcPcImm, 32'h80, aluAdd,
           loadNone, storeNone, 9, v | expIsJump);
    addRow("jal bubble", encI(6'b100111, 0, 0, 16'h0), ctlNop, srcZero, srcPcImm, 32'h0, aluAdd,
           loadNone, storeNone, 0, v | expJump);
    addRow("jal delay slot", encR(3, 4, 5, 0), ctlNone, srcRf, srcRf, 0, aluAdd, loadNone,
           storeNone, 3, v | expDelaySlot);
    addRow("jal squashed", encI(6'b100011, 7, 4, 16'h4), ctlNone, srcRf, srcPcImm, 32'h4,
           aluAdd, loadNone, storeNone, 7, expValid);
    addRow("filter reset", encR(3, 4, 5, 0), ctlResetFilter, srcRf, srcRf, 0, aluAdd, loadNone,
           storeNone, 3, v);
    addRow("final add", encR(6, 7, 8, 0), ctlFwdA, srcFwd, srcRf, 0, aluAdd, loadNone,
           storeNone, 6, v);
  endtask

  task automatic checkValue(input int row, input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected)
    else
    begin
      $display("MISMATCH time=%0t row=%0d %s expected=%h actual=%h", $time, row, name,
               expected, actual);
      rowErrors[row] = rowErrors[row] + 1;
      errors = errors + 1;
    end
  endtask

  task automatic applyRow(input int i);
    ir <= rows[i].ir;
    pc <= rows[i].pc;
    stall <= rows[i].ctl[7];
    flush <= rows[i].ctl[6];
    fastFlag <= rows[i].ctl[5];
    insertedNop <= rows[i].ctl[4];
    resetFilterIn <= rows[i].ctl[3];
    useForwardedOperandA <= rows[i].ctl[2];
    useForwardedOperandB <= rows[i].ctl[1];
    useForwardedStoreData <= rows[i].ctl[0];
    rfOperandA <= rows[i].rfA;
    rfOperandB <= rows[i].rfB;
    forwardedOperandA <= rows[i].fwdA;
    forwardedOperandB <= rows[i].fwdB;
    forwardedStoreData <= rows[i].fwdStore;
  endtask

  // a stalled row leaves the previous expectation in place
  task automatic checkCaptured(input int i);
    if (!rows[i].ctl[7])
    begin
      held = rows[i];
      heldA = sourceValue(held.srcA, held.pc, held.fwdA, held.rfA);
      heldB = sourceValue(held.srcB, held.imm, held.fwdB, held.rfB);
      heldStore = held.ctl[0] ? held.fwdStore : held.rfB;
    end
    checkValue(i, "exeOperandA", exeOperandA, heldA);
    checkValue(i, "exeOperandB", exeOperandB, heldB);
    checkValue(i, "exeStoreData", exeStoreData, heldStore);
    checkValue(i, "exeInstructionAddress", exeInstructionAddress, held.pc);
    checkValue(i, "exeAluOp", exeAluOp, held.aluOp);
    checkValue(i, "exeLoad", exeLoad, held.ld);
    checkValue(i, "exeStore", exeStore, held.st);
    checkValue(i, "exeDestination", exeDestination, held.dest);
    checkValue(i, "exeCompareCntrl", exeCompareCntrl, held.ir[24:21]);
    checkValue(i, "exeWeDestination", exeWeDestination, held.flags[5]);
    checkValue(i, "exeUpdateFlag", exeUpdateFlag, held.flags[4]);
    checkValue(i, "exeValidInstruction", exeValidInstruction, held.flags[3]);
    checkValue(i, "exeIsJump", exeIsJump, held.flags[1]);
    checkValue(i, "exeIsDelaySlot", exeIsDelaySlot, held.flags[0]);
    if (rowErrors[i] == 0)
      $display("row %0d %s: ok", i, rows[i].name);
    else
    begin
      $display("row %0d %s: failed with %0d errors", i, rows[i].name, rowErrors[i]);
      failedRows = failedRows + 1;
    end
  endtask

  initial
  begin
    void'($urandom(79));
    clock = 1'b0;
    arstN = 1'b0;
    ir = 32'hFC000000;
    pc = 32'h0;
    stall = 1'b0;
    flush = 1'b0;
    fastFlag = 1'b0;
    resetFilterIn = 1'b0;
    insertedNop = 1'b0;
    rfOperandA = 32'h0;
    rfOperandB = 32'h0;
    forwardedOperandA = 32'h0;
    forwardedOperandB = 32'h0;
    forwardedStoreData = 32'h0;
    useForwardedOperandA = 1'b0;
    useForwardedOperandB = 1'b0;
    useForwardedStoreData = 1'b0;
    buildTable();
    cycleLimit = 2 * rows.size() + 20;

    @(posedge clock);
    @(negedge clock);
    rowErrors.push_back(0);
    checkValue(rows.size(), "exeWeDestination", exeWeDestination, 0);
    checkValue(rows.size(), "exeLoad", exeLoad, loadNone);
    checkValue(rows.size(), "exeStore", exeStore, storeNone);
    checkValue(rows.size(), "exeUpdateFlag", exeUpdateFlag, 0);
    checkValue(rows.size(), "exeIsJump", exeIsJump, 0);
    checkValue(rows.size(), "jump", jump, 0);
    checkValue(rows.size(), "exeIsDelaySlot", exeIsDelaySlot, 0);
    checkValue(rows.size(), "exeValidInstruction", exeValidInstruction, 1);
    $display("reset state: %s", (rowErrors[rows.size()] == 0) ? "ok" : "failed");
    if (rowErrors[rows.size()] != 0)
      failedRows = failedRows + 1;
    @(posedge clock);
    arstN <= 1'b1;

    // jump and the lookup addresses are checked while their row sits in decode
    for (int i = 0; i <= rows.size(); i++)
    begin
      @(posedge clock);
      if (i < rows.size())
        applyRow(i);
      @(negedge clock);
      if (i > 0)
        checkCaptured(i - 1);
      if (i < rows.size())
      begin
        checkValue(i, "jump", jump, rows[i].flags[2]);
        checkValue(i, "lookupOperandAAddr", lookupOperandAAddr, rows[i].ir[20:16]);
        checkValue(i, "lookupOperandBAddr", lookupOperandBAddr, rows[i].ir[15:11]);
      end
    end

    $display("rows %0d, failed rows %0d, failed checks %0d", rows.size(), failedRows, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
decodePkg.sv
instructionClassifier.sv
operandSelect.sv
branchControl.sv
executeStageRegister.sv
decodeStage.sv
tb_decodeStage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" && verilator --binary --timing --assert -f tb.f --top-module tb_decodeStage -o simDecode || exit 1
./obj_dir/simDecode | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null && exit 0 || exit 1
